//--- sim.f
source/fm_mix_pkg.sv
source/channel_accumulator.sv
source/slot_sequencer.sv
source/slot_mixer.sv
source/fm_output_mixer.sv
bench/tb_clock.sv
bench/tb_fm_output_mixer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the output mixer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_fm_output_mixer
log=sim.log

verilator --binary --timing --assert -f sim.f --top-module "$top" \
    -Mdir obj_dir -o "V$top"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/"V$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Regression passed" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

//--- bench/tb_fm_output_mixer.sv
// Output mixer testbench with adpcm_mix set to 1
// Six frames with clk_en high on two of every three cycles
`timescale 1ns/1ps

module tb_fm_output_mixer;

    localparam int timeout_cycles = 6 * fm_mix_pkg::slots_per_frame * 3 + 64;

    logic clk;
    logic arst_n;
    logic clk_en;
    logic cfg_we;
    fm_mix_pkg::ch_t cfg_ch;
    fm_mix_pkg::ch_cfg_t cfg_data;
    fm_mix_pkg::op_result_t op_result;
    fm_mix_pkg::stereo_t adpcm_a;
    fm_mix_pkg::stereo_t adpcm_b;
    fm_mix_pkg::slot_t slot;
    fm_mix_pkg::stereo_t sample;
    logic sample_valid;

    // Reference state
    int ref_idx;
    int ref_l;
    int ref_r;
    int en_phase;
    int cycle_count;
    int value_errors;
    int protocol_errors;
    logic [31:0] rng_state;
    logic exp_valid;
    fm_mix_pkg::stereo_t exp_sample;
    fm_mix_pkg::slot_t exp_slot;
    fm_mix_pkg::ch_cfg_t cfg_copy [0:7];

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fm_output_mixer #(
        .adpcm_mix (1'b1)
    ) dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .clk_en       (clk_en),
        .cfg_we       (cfg_we),
        .cfg_ch       (cfg_ch),
        .cfg_data     (cfg_data),
        .op_result    (op_result),
        .adpcm_a      (adpcm_a),
        .adpcm_b      (adpcm_b),
        .slot         (slot),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int clamp(input int v, input int lo, input int hi);
        int r;
        r = v;
        if (v < lo) begin
            r = lo;
        end else if (v > hi) begin
            r = hi;
        end
        return r;
    endfunction

    // Slot index to channel number, skipping channel 3
    function automatic int slot_channel(input int idx);
        int pos;
        pos = idx % 6;
        return (pos < 3) ? pos : pos + 1;
    endfunction

    function automatic fm_mix_pkg::slot_t expected_slot(input int idx);
        fm_mix_pkg::slot_t s;
        int op;
        op = idx / 6;
        s.ch = 3'(slot_channel(idx));
        s.op = 2'(op);
        s.s1_enters = (op == 0);
        s.s2_enters = (op == 1);
        s.s3_enters = (op == 2);
        s.s4_enters = (op == 3);
        return s;
    endfunction

    // Carrier operators per connection algorithm
    function automatic bit is_carrier(input fm_mix_pkg::alg_t alg, input int op);
        bit r;
        case (alg)
            3'd4:       r = (op == 1) || (op == 3);
            3'd5, 3'd6: r = (op != 0);
            3'd7:       r = 1'b1;
            default:    r = (op == 3);
        endcase
        return r;
    endfunction

    // Value one slot adds to one side of the output
    function automatic int slot_term(input int idx, input bit left_side,
                                     input fm_mix_pkg::ch_cfg_t c, input int fm,
                                     input int a, input int b);
        int op;
        int ch;
        int r;
        op = idx / 6;
        ch = slot_channel(idx);
        r = 0;
        if (op == 0 && ch == int'(fm_mix_pkg::adpcm_a_ch)) begin
            r = clamp(a * 8, -131072, 131071);
        end else if (op == 0 && ch == int'(fm_mix_pkg::adpcm_b_ch)) begin
            r = b >>> 1;
        end else if (is_carrier(c.alg, op) && (left_side ? c.rl[1] : c.rl[0])) begin
            r = fm;
        end
        return r;
    endfunction

    assign exp_slot = expected_slot(ref_idx);

    // Reference frame sums on the DUT's clock edges
    always @(posedge clk or negedge arst_n) begin
        int term_l;
        int term_r;
        if (!arst_n) begin
            ref_idx <= 0;
            ref_l <= 0;
            ref_r <= 0;
            exp_valid <= 1'b0;
            exp_sample <= '0;
            for (int i = 0; i < 8; i++) begin
                cfg_copy[i] <= '0;
            end
        end else begin
            exp_valid <= clk_en && (ref_idx == 0);
            if (cfg_we) begin
                cfg_copy[cfg_ch] <= cfg_data;
            end
            if (clk_en) begin
                term_l = slot_term(ref_idx, 1'b1, cfg_copy[slot_channel(ref_idx)],
                                   int'(op_result), int'(adpcm_a.left), int'(adpcm_b.left));
                term_r = slot_term(ref_idx, 1'b0, cfg_copy[slot_channel(ref_idx)],
                                   int'(op_result), int'(adpcm_a.right), int'(adpcm_b.right));
                if (ref_idx == 0) begin
                    // Frame boundary
                    exp_sample.left <= 16'(clamp(ref_l, -32768, 32767));
                    exp_sample.right <= 16'(clamp(ref_r, -32768, 32767));
                    ref_l <= term_l;
                    ref_r <= term_r;
                end else begin
                    ref_l <= clamp(ref_l + term_l, -131072, 131071);
                    ref_r <= clamp(ref_r + term_r, -131072, 131071);
                end
                ref_idx <= (ref_idx == fm_mix_pkg::slots_per_frame - 1) ? 0 : ref_idx + 1;
            end
        end
    end

    a_slot: assert property (@(posedge clk) disable iff (!arst_n) slot == exp_slot)
        else begin
            value_errors++;
            $display("CHECK FAILED slot expected %h got %h", $sampled(exp_slot), $sampled(slot));
        end

    a_left: assert property (@(posedge clk) disable iff (!arst_n)
        sample.left == exp_sample.left)
        else begin
            value_errors++;
            $display("CHECK FAILED sample.left expected %h got %h",
                     $sampled(exp_sample.left), $sampled(sample.left));
        end

    a_right: assert property (@(posedge clk) disable iff (!arst_n)
        sample.right == exp_sample.right)
        else begin
            value_errors++;
            $display("CHECK FAILED sample.right expected %h got %h",
                     $sampled(exp_sample.right), $sampled(sample.right));
        end

    // Held between strobes
    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !sample_valid |-> $stable(sample))
        else begin
            protocol_errors++;
            $display("Sample changed without a sample_valid strobe");
        end

    a_strobe: assert property (@(posedge clk) disable iff (!arst_n) exp_valid |-> sample_valid)
        else begin
            protocol_errors++;
            $display("Missing sample_valid strobe one clock after slot 0");
        end

    a_extra: assert property (@(posedge clk) disable iff (!arst_n) sample_valid |-> exp_valid)
        else begin
            protocol_errors++;
            $display("Unexpected sample_valid strobe away from the frame boundary");
        end

    task automatic print_counts();
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    endtask

    // Returns 2 ns after the edge where sample_valid is seen high
    task automatic wait_frame();
        do begin
            @(posedge clk);
            #2;
        end while (!sample_valid);
    endtask

    task automatic write_cfg(input int ch, input fm_mix_pkg::alg_t alg, input fm_mix_pkg::rl_t rl);
        cfg_we = 1'b1;
        cfg_ch = 3'(ch);
        cfg_data = {alg, rl};
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
    endtask

    // Operator data and clk_en on two of three cycles
    initial begin
        rng_state = 32'd81;
        en_phase = 0;
        clk_en = 1'b0;
        op_result = '0;
        forever begin
            @(posedge clk);
            #2;
            rng_state = xorshift32(rng_state);
            op_result = rng_state[13:0];
            clk_en = (en_phase != 2);
            en_phase = (en_phase == 2) ? 0 : en_phase + 1;
        end
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        protocol_errors++;
        $display("Timeout after %0d cycles without finishing the frames", cycle_count);
        print_counts();
        $display("Regression failed");
        $finish;
    end

    initial begin
        value_errors = 0;
        protocol_errors = 0;
        cfg_we = 1'b0;
        cfg_ch = '0;
        cfg_data = '0;
        adpcm_a = '0;
        adpcm_b = '0;
        wait (arst_n === 1'b1);
        // Silent frames with reset configuration
        wait_frame();
        wait_frame();
        // Algorithm 0 on both sides
        for (int p = 0; p < 6; p++) begin
            write_cfg(slot_channel(p), 3'd0, 2'b11);
        end
        wait_frame();
        // Mixed algorithms and single-side panning with small ADPCM
        adpcm_a = {16'sh0123, 16'shfe00};
        adpcm_b = {16'sh0f01, 16'shf0ff};
        write_cfg(0, 3'd4, 2'b11);
        write_cfg(1, 3'd5, 2'b11);
        write_cfg(2, 3'd7, 2'b10);
        write_cfg(4, 3'd7, 2'b01);
        write_cfg(5, 3'd6, 2'b10);
        write_cfg(6, 3'd0, 2'b01);
        wait_frame();
        // Full-scale ADPCM drives both clip limits
        adpcm_a = {16'sh7fff, 16'sh8000};
        adpcm_b = {16'sh7fff, 16'sh8000};
        for (int p = 0; p < 6; p++) begin
            write_cfg(slot_channel(p), 3'd7, 2'b11);
        end
        wait_frame();
        wait_frame();
        print_counts();
        if (value_errors + protocol_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
// Free-running clock and power-on reset for the testbench
// Reset releases 2 ns after the last reset edge, in step with the stimulus
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset held low for a few rising edges
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        arst_n = 1'b1;
    end

endmodule

//--- source/fm_output_mixer.sv
// YM2610 output mixer, op_result must match the exported slot on clk_en cycles
// No back-pressure, sample is held until the next sample_valid
`timescale 1ns/1ps

module fm_output_mixer #(
    parameter bit adpcm_mix = 1'b1
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clk_en,
    input  logic                   cfg_we,
    input  fm_mix_pkg::ch_t        cfg_ch,
    input  fm_mix_pkg::ch_cfg_t    cfg_data,
    input  fm_mix_pkg::op_result_t op_result,
    input  fm_mix_pkg::stereo_t    adpcm_a,
    input  fm_mix_pkg::stereo_t    adpcm_b,
    output fm_mix_pkg::slot_t      slot,
    output fm_mix_pkg::stereo_t    sample,
    output logic                   sample_valid
);

    // Settings of the channel in the current slot
    fm_mix_pkg::ch_cfg_t cur_cfg;
    // High during slot 0
    logic frame_zero;

    slot_sequencer u_sequencer (
        .clk      (clk),
        .arst_n   (arst_n),
        .clk_en   (clk_en),
        .cfg_we   (cfg_we),
        .cfg_ch   (cfg_ch),
        .cfg_data (cfg_data),
        .slot     (slot),
        .cfg      (cur_cfg),
        .zero     (frame_zero)
    );

    slot_mixer #(
        .adpcm_mix (adpcm_mix)
    ) u_mixer (
        .clk          (clk),
        .arst_n       (arst_n),
        .clk_en       (clk_en),
        .slot         (slot),
        .cfg          (cur_cfg),
        .zero         (frame_zero),
        .op_result    (op_result),
        .adpcm_a      (adpcm_a),
        .adpcm_b      (adpcm_b),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

//--- source/slot_mixer.sv
// Carrier selection and panning per slot, feeding left and right accumulators
// ADPCM-A times 8 is clamped to the accumulator range before summing
`timescale 1ns/1ps

module slot_mixer #(
    parameter bit adpcm_mix = 1'b1
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clk_en,
    input  fm_mix_pkg::slot_t      slot,
    input  fm_mix_pkg::ch_cfg_t    cfg,
    input  logic                   zero,
    input  fm_mix_pkg::op_result_t op_result,
    input  fm_mix_pkg::stereo_t    adpcm_a,
    input  fm_mix_pkg::stereo_t    adpcm_b,
    output fm_mix_pkg::stereo_t    sample,
    output logic                   sample_valid
);

    logic sum_en;
    logic is_adpcm_a;
    logic is_adpcm_b;
    fm_mix_pkg::acc_t din_l;
    fm_mix_pkg::acc_t din_r;
    logic en_l;
    logic en_r;
    // ADPCM-B halved, still fits 16 bits
    fm_mix_pkg::adpcm_t b_half_l;
    fm_mix_pkg::adpcm_t b_half_r;

    // Carrier operators per algorithm
    always_comb begin
        case (cfg.alg)
            3'd4:       sum_en = slot.s2_enters | slot.s4_enters;
            3'd5, 3'd6: sum_en = slot.s2_enters | slot.s3_enters | slot.s4_enters;
            3'd7:       sum_en = slot.s1_enters | slot.s2_enters | slot.s3_enters |
                                 slot.s4_enters;
            default:    sum_en = slot.s4_enters;
        endcase
    end

    assign is_adpcm_a = (slot.op == 2'd0) && (slot.ch == fm_mix_pkg::adpcm_a_ch);
    assign is_adpcm_b = (slot.op == 2'd0) && (slot.ch == fm_mix_pkg::adpcm_b_ch);

    assign b_half_l = adpcm_b.left >>> 1;
    assign b_half_r = adpcm_b.right >>> 1;

    // Input select, FM data of the ADPCM slots is dropped
    always_comb begin
        if (is_adpcm_a) begin
            din_l = fm_mix_pkg::sat_acc(19'(adpcm_a.left) <<< 3);
            din_r = fm_mix_pkg::sat_acc(19'(adpcm_a.right) <<< 3);
            en_l  = adpcm_mix;
            en_r  = adpcm_mix;
        end else if (is_adpcm_b) begin
            din_l = 18'(b_half_l);
            din_r = 18'(b_half_r);
            en_l  = adpcm_mix;
            en_r  = adpcm_mix;
        end else begin
            // Sign extend operator output
            din_l = 18'(op_result);
            din_r = 18'(op_result);
            en_l  = sum_en & cfg.rl[1];
            en_r  = sum_en & cfg.rl[0];
        end
    end

    // Strobe trails the slot 0 step by one clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= clk_en & zero;
        end
    end

    channel_accumulator u_left (
        .clk    (clk),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .din    (din_l),
        .sum_en (en_l),
        .zero   (zero),
        .snd    (sample.left)
    );

    channel_accumulator u_right (
        .clk    (clk),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .din    (din_r),
        .sum_en (en_r),
        .zero   (zero),
        .snd    (sample.right)
    );

endmodule

//--- source/slot_sequencer.sv
// Walks 24 slots per frame, operator-major, one step per clk_en
// Writes to channels 3 and 7 are ignored
`timescale 1ns/1ps

module slot_sequencer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                clk_en,
    input  logic                cfg_we,
    input  fm_mix_pkg::ch_t     cfg_ch,
    input  fm_mix_pkg::ch_cfg_t cfg_data,
    output fm_mix_pkg::slot_t   slot,
    output fm_mix_pkg::ch_cfg_t cfg,
    output logic                zero
);

    logic [4:0] cnt;
    logic [4:0] base;
    // Channel position 0..5 inside the current operator
    logic [2:0] ch_idx;
    fm_mix_pkg::op_t op;
    logic [2:0] wr_idx;
    logic wr_ok;
    fm_mix_pkg::ch_cfg_t cfg_regs [0:5];

    // Frame slot counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (clk_en) begin
            if (cnt == 5'(fm_mix_pkg::slots_per_frame - 1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 5'd1;
            end
        end
    end

    // Split counter into operator and channel position
    always_comb begin
        if (cnt >= 5'd18) begin
            op   = 2'd3;
            base = 5'd18;
        end else if (cnt >= 5'd12) begin
            op   = 2'd2;
            base = 5'd12;
        end else if (cnt >= 5'd6) begin
            op   = 2'd1;
            base = 5'd6;
        end else begin
            op   = 2'd0;
            base = 5'd0;
        end
        ch_idx = 3'(cnt - base);
    end

    // Slot descriptor
    always_comb begin
        // Positions 3..5 map to channels 4..6
        slot.ch        = (ch_idx < 3'd3) ? ch_idx : ch_idx + 3'd1;
        slot.op        = op;
        slot.s1_enters = (op == 2'd0);
        slot.s2_enters = (op == 2'd1);
        slot.s3_enters = (op == 2'd2);
        slot.s4_enters = (op == 2'd3);
    end

    assign zero = (cnt == 5'd0);

    // Register write index, channel 3 and 7 have no storage
    assign wr_ok  = (cfg_ch[1:0] != 2'd3);
    assign wr_idx = cfg_ch[2] ? cfg_ch - 3'd1 : cfg_ch;

    // Per-channel algorithm and panning, written independent of clk_en
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 6; i++) begin
                cfg_regs[i] <= '0;
            end
        end else if (cfg_we && wr_ok) begin
            cfg_regs[wr_idx] <= cfg_data;
        end
    end

    // Current channel settings
    assign cfg = cfg_regs[ch_idx];

    // Counter must wrap before leaving the frame
    a_cnt_in_frame: assert property (
        @(posedge clk) disable iff (!arst_n)
        cnt < 5'(fm_mix_pkg::slots_per_frame)
    ) else $error("slot counter out of frame range: %0d", cnt);

endmodule

//--- source/channel_accumulator.sv
// Frame accumulator, running sum clamps at 18 bits and the output at 16
`timescale 1ns/1ps

module channel_accumulator (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             clk_en,
    input  fm_mix_pkg::acc_t din,
    input  logic             sum_en,
    input  logic             zero,
    output fm_mix_pkg::snd_t snd
);

    fm_mix_pkg::acc_t sum;
    fm_mix_pkg::acc_t sum_next;
    fm_mix_pkg::snd_t sum_sat;

    // Add with headroom, then clamp back
    assign sum_next = fm_mix_pkg::sat_acc(19'(sum) + 19'(din));

    // Output range clamp
    always_comb begin
        if (sum[17:15] == 3'b000 || sum[17:15] == 3'b111) begin
            sum_sat = sum[15:0];
        end else if (sum[17]) begin
            sum_sat = 16'sh8000;
        end else begin
            sum_sat = 16'sh7fff;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                // Frame boundary, latch old sum and restart
                snd <= sum_sat;
                sum <= sum_en ? din : '0;
            end else if (sum_en) begin
                sum <= sum_next;
            end
        end
    end

    // Held output only moves on the frame boundary step
    a_hold_between_frames: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(clk_en && zero) |=> $stable(snd)
    ) else $error("accumulator output changed outside frame boundary");

endmodule

//--- source/fm_mix_pkg.sv
// Shared types and constants for the YM2610 output accumulator
// Channel numbers skip 3, so only six of the eight ch_t codes are valid
package fm_mix_pkg;

    // Sample and accumulator widths
    typedef logic signed [13:0] op_result_t;
    typedef logic signed [15:0] adpcm_t;
    typedef logic signed [15:0] snd_t;
    typedef logic signed [17:0] acc_t;

    // Slot addressing and channel settings
    typedef logic [2:0] ch_t;
    typedef logic [1:0] op_t;
    typedef logic [2:0] alg_t;
    // Bit 1 left, bit 0 right
    typedef logic [1:0] rl_t;

    // Current slot, exactly one enters flag set
    typedef struct packed {
        ch_t  ch;
        op_t  op;
        logic s1_enters;
        logic s2_enters;
        logic s3_enters;
        logic s4_enters;
    } slot_t;

    typedef struct packed {
        alg_t alg;
        rl_t  rl;
    } ch_cfg_t;

    typedef struct packed {
        snd_t left;
        snd_t right;
    } stereo_t;

    localparam int slots_per_frame = 24;
    // FM channels replaced on operator 0
    localparam ch_t adpcm_a_ch = 3'd2;
    localparam ch_t adpcm_b_ch = 3'd6;

    // Clamp a 19-bit intermediate into the accumulator range
    function automatic acc_t sat_acc(input logic signed [18:0] x);
        // Two top bits differ only on overflow
        if (x[18] != x[17]) begin
            return x[18] ? 18'sh20000 : 18'sh1ffff;
        end
        return x[17:0];
    endfunction

endpackage
